// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen      = 64;
    localparam int inst_w    = 32;
    localparam int reg_idx_w = 5;

    // instruction field positions
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int funct7_lsb = 25;

    // major opcodes, inst[6:0]
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;
    localparam logic [6:0] opc_jal       = 7'b1101111;
    localparam logic [6:0] opc_jalr      = 7'b1100111;
    localparam logic [6:0] opc_branch    = 7'b1100011;
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] opc_op_imm    = 7'b0010011;
    localparam logic [6:0] opc_op_imm_32 = 7'b0011011; // addiw and w shifts
    localparam logic [6:0] opc_op        = 7'b0110011;
    localparam logic [6:0] opc_op_32     = 7'b0111011;

    typedef enum logic [3:0] {
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_load,
        cls_store,
        cls_alu_imm,
        cls_alu_imm_w,
        cls_alu_reg,
        cls_alu_reg_w,
        cls_illegal
    } op_class_e;

    typedef enum logic [5:0] {
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        op_sb, op_sh, op_sw, op_sd,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        op_addiw, op_slliw, op_srliw, op_sraiw,
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and,
        op_addw, op_subw, op_sllw, op_srlw, op_sraw,
        op_lui, op_auipc, op_jal, op_jalr,
        op_illegal
    } rv_op_e;

endpackage

// File: common/decode_pkg.sv
package decode_pkg;

    // instruction queue between fetch and the head slot
    localparam int queue_depth    = 8;
    localparam int queue_ptr_w    = 3;
    localparam int queue_cnt_w    = queue_ptr_w + 1; // counts 0..queue_depth

    // ready drops here, leaves room for pairs fetch has in flight
    localparam int queue_alm_full = 6;

    // integer register file
    localparam int reg_count      = 32;

endpackage

// File: common/id_slot_if.sv
interface id_slot_if;
    import rv_isa_pkg::*;

    logic              valid;
    logic [xlen-1:0]   pc;
    logic [inst_w-1:0] inst;
    logic              advance; // slot moves on this edge

    modport producer (
        output valid, pc, inst,
        input  advance
    );

    modport consumer (
        input valid, pc, inst
    );

    modport ctrl (
        input  valid, inst,
        output advance
    );

endinterface

// File: decode/fetch_buffer.sv
module fetch_buffer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [rv_isa_pkg::xlen-1:0]   in_pc,
    input  logic [rv_isa_pkg::inst_w-1:0] in_inst,
    id_slot_if.producer                   slot
);
    import rv_isa_pkg::*;
    import decode_pkg::*;

    logic [xlen-1:0]        q_pc   [queue_depth];
    logic [inst_w-1:0]      q_inst [queue_depth];
    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_ptr_w-1:0] rd_ptr;
    logic [queue_cnt_w-1:0] count;
    logic                   q_empty;
    logic                   accept;
    logic                   bypass;
    logic                   q_wr;
    logic                   q_rd;

    assign q_empty  = (count == '0);
    assign in_ready = (count < queue_cnt_w'(queue_alm_full));
    assign accept   = in_valid && in_ready && !flush; // flush drops the pair too
    assign bypass   = accept && q_empty && slot.advance; // straight into the slot
    assign q_wr     = accept && !bypass;
    assign q_rd     = slot.advance && !q_empty;

    always_ff @(posedge clk) begin
        if (q_wr) begin
            q_pc[wr_ptr]   <= in_pc;
            q_inst[wr_ptr] <= in_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (q_wr) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at queue_depth
            end
            if (q_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (q_wr && !q_rd) begin
                count <= count + 1'b1;
            end else if (q_rd && !q_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // head slot, filled from the queue first so order holds
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            slot.valid <= 1'b0;
        end else if (slot.advance) begin
            slot.valid <= !q_empty || accept;
        end
    end

    always_ff @(posedge clk) begin
        if (slot.advance) begin
            if (!q_empty) begin
                slot.pc   <= q_pc[rd_ptr];
                slot.inst <= q_inst[rd_ptr];
            end else begin
                slot.pc   <= in_pc; // only meaningful when accepted
                slot.inst <= in_inst;
            end
        end
    end

endmodule

// File: decode/inst_decoder.sv
module inst_decoder (
    id_slot_if.consumer                      slot,
    output rv_isa_pkg::op_class_e            op_class,
    output rv_isa_pkg::rv_op_e               op,
    output logic [rv_isa_pkg::reg_idx_w-1:0] rd,
    output logic [rv_isa_pkg::reg_idx_w-1:0] rs1,
    output logic [rv_isa_pkg::reg_idx_w-1:0] rs2,
    output logic [rv_isa_pkg::xlen-1:0]      imm
);
    import rv_isa_pkg::*;

    logic [inst_w-1:0] inst;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    op_class_e         major_class;
    logic [xlen-1:0]   imm_i;
    logic [xlen-1:0]   imm_s;
    logic [xlen-1:0]   imm_b;
    logic [xlen-1:0]   imm_u;
    logic [xlen-1:0]   imm_j;

    assign inst   = slot.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[funct3_lsb +: 3];
    assign funct7 = inst[funct7_lsb +: 7];
    assign rd     = inst[rd_lsb +: reg_idx_w];
    assign rs1    = inst[rs1_lsb +: reg_idx_w];
    assign rs2    = inst[rs2_lsb +: reg_idx_w];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opcode)
            opc_lui:       major_class = cls_lui;
            opc_auipc:     major_class = cls_auipc;
            opc_jal:       major_class = cls_jal;
            opc_jalr:      major_class = cls_jalr;
            opc_branch:    major_class = cls_branch;
            opc_load:      major_class = cls_load;
            opc_store:     major_class = cls_store;
            opc_op_imm:    major_class = cls_alu_imm;
            opc_op_imm_32: major_class = cls_alu_imm_w;
            opc_op:        major_class = cls_alu_reg;
            opc_op_32:     major_class = cls_alu_reg_w;
            default:       major_class = cls_illegal;
        endcase
    end

    // funct7 lsb is shamt[5] for the 64-bit immediate shifts
    always_comb begin
        casez ({funct7, funct3, opcode})
            {7'b???????, 3'b???, opc_lui}:       op = op_lui;
            {7'b???????, 3'b???, opc_auipc}:     op = op_auipc;
            {7'b???????, 3'b???, opc_jal}:       op = op_jal;
            {7'b???????, 3'b000, opc_jalr}:      op = op_jalr;
            {7'b???????, 3'b000, opc_branch}:    op = op_beq;
            {7'b???????, 3'b001, opc_branch}:    op = op_bne;
            {7'b???????, 3'b100, opc_branch}:    op = op_blt;
            {7'b???????, 3'b101, opc_branch}:    op = op_bge;
            {7'b???????, 3'b110, opc_branch}:    op = op_bltu;
            {7'b???????, 3'b111, opc_branch}:    op = op_bgeu;
            {7'b???????, 3'b000, opc_load}:      op = op_lb;
            {7'b???????, 3'b001, opc_load}:      op = op_lh;
            {7'b???????, 3'b010, opc_load}:      op = op_lw;
            {7'b???????, 3'b011, opc_load}:      op = op_ld;
            {7'b???????, 3'b100, opc_load}:      op = op_lbu;
            {7'b???????, 3'b101, opc_load}:      op = op_lhu;
            {7'b???????, 3'b110, opc_load}:      op = op_lwu;
            {7'b???????, 3'b000, opc_store}:     op = op_sb;
            {7'b???????, 3'b001, opc_store}:     op = op_sh;
            {7'b???????, 3'b010, opc_store}:     op = op_sw;
            {7'b???????, 3'b011, opc_store}:     op = op_sd;
            {7'b???????, 3'b000, opc_op_imm}:    op = op_addi;
            {7'b???????, 3'b010, opc_op_imm}:    op = op_slti;
            {7'b???????, 3'b011, opc_op_imm}:    op = op_sltiu;
            {7'b???????, 3'b100, opc_op_imm}:    op = op_xori;
            {7'b???????, 3'b110, opc_op_imm}:    op = op_ori;
            {7'b???????, 3'b111, opc_op_imm}:    op = op_andi;
            {7'b000000?, 3'b001, opc_op_imm}:    op = op_slli;
            {7'b000000?, 3'b101, opc_op_imm}:    op = op_srli;
            {7'b010000?, 3'b101, opc_op_imm}:    op = op_srai;
            {7'b???????, 3'b000, opc_op_imm_32}: op = op_addiw;
            {7'b0000000, 3'b001, opc_op_imm_32}: op = op_slliw;
            {7'b0000000, 3'b101, opc_op_imm_32}: op = op_srliw;
            {7'b0100000, 3'b101, opc_op_imm_32}: op = op_sraiw;
            {7'b0000000, 3'b000, opc_op}:        op = op_add;
            {7'b0100000, 3'b000, opc_op}:        op = op_sub;
            {7'b0000000, 3'b001, opc_op}:        op = op_sll;
            {7'b0000000, 3'b010, opc_op}:        op = op_slt;
            {7'b0000000, 3'b011, opc_op}:        op = op_sltu;
            {7'b0000000, 3'b100, opc_op}:        op = op_xor;
            {7'b0000000, 3'b101, opc_op}:        op = op_srl;
            {7'b0100000, 3'b101, opc_op}:        op = op_sra;
            {7'b0000000, 3'b110, opc_op}:        op = op_or;
            {7'b0000000, 3'b111, opc_op}:        op = op_and;
            {7'b0000000, 3'b000, opc_op_32}:     op = op_addw;
            {7'b0100000, 3'b000, opc_op_32}:     op = op_subw;
            {7'b0000000, 3'b001, opc_op_32}:     op = op_sllw;
            {7'b0000000, 3'b101, opc_op_32}:     op = op_srlw;
            {7'b0100000, 3'b101, opc_op_32}:     op = op_sraw;
            default:                             op = op_illegal;
        endcase
    end

    // a bad funct field makes the whole instruction illegal
    assign op_class = (op == op_illegal) ? cls_illegal : major_class;

    always_comb begin
        case (op_class)
            cls_lui, cls_auipc: imm = imm_u;
            cls_jal:            imm = imm_j;
            cls_branch:         imm = imm_b;
            cls_store:          imm = imm_s;
            cls_jalr, cls_load, cls_alu_imm, cls_alu_imm_w: begin
                imm = imm_i; // shifts keep shamt in the low bits
            end
            default:            imm = '0; // register-register and illegal
        endcase
    end

endmodule

// File: decode/issue_ctrl.sv
module issue_ctrl (
    id_slot_if.ctrl                       slot,
    input  rv_isa_pkg::op_class_e         op_class,
    input  logic                          ex_stage_valid,
    input  logic [rv_isa_pkg::inst_w-1:0] ex_stage_inst,
    input  logic                          ex_ready,
    output logic                          ex_valid
);
    import rv_isa_pkg::*;

    logic [reg_idx_w-1:0] ex_rd;
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    logic                 ex_load;
    logic                 uses_rs1;
    logic                 uses_rs2;
    logic                 rs1_hit;
    logic                 rs2_hit;
    logic                 blocked;

    assign ex_rd   = ex_stage_inst[rd_lsb +: reg_idx_w];
    assign rs1     = slot.inst[rs1_lsb +: reg_idx_w];
    assign rs2     = slot.inst[rs2_lsb +: reg_idx_w];
    assign ex_load = (ex_stage_inst[6:0] == opc_load) && (ex_rd != '0);

    assign uses_rs1 = !(op_class inside {cls_lui, cls_auipc, cls_jal});
    assign uses_rs2 = op_class inside {cls_branch, cls_store, cls_alu_reg, cls_alu_reg_w};

    assign rs1_hit = uses_rs1 && (ex_rd == rs1);
    assign rs2_hit = uses_rs2 && (ex_rd == rs2);

    // load data is not there until after execute, hold one cycle
    assign blocked = slot.valid && ex_stage_valid && ex_load && (rs1_hit || rs2_hit);

    assign ex_valid     = slot.valid && !blocked;
    assign slot.advance = !slot.valid || (ex_valid && ex_ready); // empty slot always refills

endmodule

// File: hdl/reg_file.sv
module reg_file (
    input  logic                             clk,
    input  logic                             reset,
    id_slot_if.consumer                      slot,
    input  logic                             wb_en,
    input  logic [rv_isa_pkg::reg_idx_w-1:0] wb_rd,
    input  logic [rv_isa_pkg::xlen-1:0]      wb_data,
    output logic [rv_isa_pkg::xlen-1:0]      src_a,
    output logic [rv_isa_pkg::xlen-1:0]      src_b
);
    import rv_isa_pkg::*;
    import decode_pkg::*;

    logic [xlen-1:0]      regs [1:reg_count-1]; // x0 has no storage
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;

    assign rs1 = slot.inst[rs1_lsb +: reg_idx_w];
    assign rs2 = slot.inst[rs2_lsb +: reg_idx_w];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // reads see a write only after its edge
    assign src_a = (rs1 == '0) ? '0 : regs[rs1];
    assign src_b = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hdl/decode_stage.sv
module decode_stage (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             flush,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  logic [rv_isa_pkg::xlen-1:0]      in_pc,
    input  logic [rv_isa_pkg::inst_w-1:0]    in_inst,
    input  logic                             wb_en,
    input  logic [rv_isa_pkg::reg_idx_w-1:0] wb_rd,
    input  logic [rv_isa_pkg::xlen-1:0]      wb_data,
    input  logic                             ex_stage_valid,
    input  logic [rv_isa_pkg::inst_w-1:0]    ex_stage_inst,
    output logic                             ex_valid,
    input  logic                             ex_ready,
    output logic [rv_isa_pkg::xlen-1:0]      ex_pc,
    output logic [rv_isa_pkg::inst_w-1:0]    ex_inst,
    output rv_isa_pkg::op_class_e            op_class,
    output rv_isa_pkg::rv_op_e               op,
    output logic [rv_isa_pkg::reg_idx_w-1:0] rd,
    output logic [rv_isa_pkg::xlen-1:0]      imm,
    output logic [rv_isa_pkg::xlen-1:0]      src_a,
    output logic [rv_isa_pkg::xlen-1:0]      src_b
);

    id_slot_if slot ();

    fetch_buffer u_fetch_buffer (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_pc    (in_pc),
        .in_inst  (in_inst),
        .slot     (slot.producer)
    );

    inst_decoder u_inst_decoder (
        .slot     (slot.consumer),
        .op_class (op_class),
        .op       (op),
        .rd       (rd),
        .rs1      (), // register file takes the indices from the slot itself
        .rs2      (),
        .imm      (imm)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .slot    (slot.consumer),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .src_a   (src_a),
        .src_b   (src_b)
    );

    issue_ctrl u_issue_ctrl (
        .slot           (slot.ctrl),
        .op_class       (op_class),
        .ex_stage_valid (ex_stage_valid),
        .ex_stage_inst  (ex_stage_inst),
        .ex_ready       (ex_ready),
        .ex_valid       (ex_valid)
    );

    assign ex_pc   = slot.pc;
    assign ex_inst = slot.inst;

endmodule

// File: testbench/tb_decode_stage.sv
module tb_decode_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_isa_pkg::*;
    import decode_pkg::*;

    typedef struct packed {
        logic [xlen-1:0]   pc;
        logic [inst_w-1:0] inst;
    } pair_t;

    // lookup by funct3
    localparam rv_op_e branch_ops [8] = '{op_beq, op_bne, op_illegal, op_illegal,
                                          op_blt, op_bge, op_bltu, op_bgeu};
    localparam rv_op_e load_ops [8]   = '{op_lb, op_lh, op_lw, op_ld,
                                          op_lbu, op_lhu, op_lwu, op_illegal};
    localparam rv_op_e store_ops [8]  = '{op_sb, op_sh, op_sw, op_sd,
                                          op_illegal, op_illegal, op_illegal, op_illegal};
    localparam rv_op_e imm_ops [8]    = '{op_addi, op_slli, op_slti, op_sltiu,
                                          op_xori, op_srli, op_ori, op_andi};
    localparam rv_op_e imm_w_ops [8]  = '{op_addiw, op_slliw, op_illegal, op_illegal,
                                          op_illegal, op_srliw, op_illegal, op_illegal};
    localparam rv_op_e reg_ops [8]    = '{op_add, op_sll, op_slt, op_sltu,
                                          op_xor, op_srl, op_or, op_and};
    localparam rv_op_e reg_w_ops [8]  = '{op_addw, op_sllw, op_illegal, op_illegal,
                                          op_illegal, op_srlw, op_illegal, op_illegal};
    localparam logic [6:0] major_opc [11] = '{opc_lui, opc_auipc, opc_jal, opc_jalr,
        opc_branch, opc_load, opc_store, opc_op_imm, opc_op_imm_32, opc_op, opc_op_32};

    logic                 clk, reset, flush;
    logic                 in_valid, in_ready;
    logic [xlen-1:0]      in_pc;
    logic [inst_w-1:0]    in_inst;
    logic                 wb_en;
    logic [reg_idx_w-1:0] wb_rd;
    logic [xlen-1:0]      wb_data;
    logic                 ex_stage_valid;
    logic [inst_w-1:0]    ex_stage_inst;
    logic                 ex_valid, ex_ready;
    logic [xlen-1:0]      ex_pc;
    logic [inst_w-1:0]    ex_inst;
    op_class_e            op_class;
    rv_op_e               op;
    logic [reg_idx_w-1:0] rd;
    logic [xlen-1:0]      imm, src_a, src_b;

    logic [31:0]     lfsr = 32'he81c;
    pair_t           exp_q[$];           // accepted and not yet taken by execute
    logic [xlen-1:0] model_regs [reg_count];
    logic [xlen-1:0] next_pc;
    logic            pair_done;          // pair on the inputs is gone at the next edge
    logic            traffic_on, hazard_on, flush_on;
    int              ready_level;        // ex_ready high for ready_level out of 8
    int              taken_count, hazard_count, flush_count, full_count;

    decode_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic value_error(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        $display("[ERROR] %0d ns %s expected %h actual %h", $time, name, expected, actual);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic plain_error(input string what);
        $display("%s at %0d ns", what, $time);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped");
    endtask

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic rv_op_e ref_op(input logic [inst_w-1:0] inst);
        logic [2:0] f3;
        logic [6:0] f7;
        rv_op_e     o;
        f3 = inst[14:12];
        f7 = inst[31:25];
        o  = op_illegal;
        case (inst[6:0])
            opc_lui:    o = op_lui;
            opc_auipc:  o = op_auipc;
            opc_jal:    o = op_jal;
            opc_jalr:   o = (f3 == 3'd0) ? op_jalr : op_illegal;
            opc_branch: o = branch_ops[f3];
            opc_load:   o = load_ops[f3];
            opc_store:  o = store_ops[f3];
            opc_op_imm: begin
                o = imm_ops[f3];
                // bit 25 is shamt[5] here
                if (f3 == 3'd5 && f7[6:1] == 6'h10) begin
                    o = op_srai;
                end else if ((f3 == 3'd1 || f3 == 3'd5) && f7[6:1] != 6'h00) begin
                    o = op_illegal;
                end
            end
            opc_op_imm_32: begin
                o = imm_w_ops[f3];
                if (f3 == 3'd5 && f7 == 7'h20) begin
                    o = op_sraiw;
                end else if ((f3 == 3'd1 || f3 == 3'd5) && f7 != 7'h00) begin
                    o = op_illegal;
                end
            end
            opc_op: begin
                if (f7 == 7'h00) begin
                    o = reg_ops[f3];
                end else if (f7 == 7'h20) begin
                    o = (f3 == 3'd0) ? op_sub : (f3 == 3'd5) ? op_sra : op_illegal;
                end
            end
            opc_op_32: begin
                if (f7 == 7'h00) begin
                    o = reg_w_ops[f3];
                end else if (f7 == 7'h20) begin
                    o = (f3 == 3'd0) ? op_subw : (f3 == 3'd5) ? op_sraw : op_illegal;
                end
            end
            default: o = op_illegal;
        endcase
        return o;
    endfunction

    function automatic op_class_e ref_class(input logic [inst_w-1:0] inst);
        if (ref_op(inst) == op_illegal) begin
            return cls_illegal;
        end
        case (inst[6:0])
            opc_lui:       return cls_lui;
            opc_auipc:     return cls_auipc;
            opc_jal:       return cls_jal;
            opc_jalr:      return cls_jalr;
            opc_branch:    return cls_branch;
            opc_load:      return cls_load;
            opc_store:     return cls_store;
            opc_op_imm:    return cls_alu_imm;
            opc_op_imm_32: return cls_alu_imm_w;
            opc_op:        return cls_alu_reg;
            default:       return cls_alu_reg_w;
        endcase
    endfunction

    function automatic logic [xlen-1:0] ref_imm(input logic [inst_w-1:0] inst);
        logic signed [xlen-1:0] v;
        case (ref_class(inst))
            cls_lui, cls_auipc: v = $signed({inst[31:12], 12'h000});
            cls_jal:    v = $signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0});
            cls_branch: v = $signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0});
            cls_store:  v = $signed({inst[31:25], inst[11:7]});
            cls_jalr, cls_load, cls_alu_imm, cls_alu_imm_w: v = $signed(inst[31:20]);
            default:    v = '0;
        endcase
        return v;
    endfunction

    // load in execute whose result the slot instruction still needs
    function automatic logic load_hit(input logic [inst_w-1:0] inst,
                                      input logic [inst_w-1:0] ex_i);
        op_class_e cls;
        cls = ref_class(inst);
        if (ex_i[6:0] != opc_load || ex_i[11:7] == 5'd0) begin
            return 1'b0;
        end
        if (ex_i[11:7] == inst[19:15] && !(cls inside {cls_lui, cls_auipc, cls_jal})) begin
            return 1'b1;
        end
        return (ex_i[11:7] == inst[24:20]) &&
               (cls inside {cls_branch, cls_store, cls_alu_reg, cls_alu_reg_w});
    endfunction

    function automatic logic [inst_w-1:0] rand_inst();
        logic [3:0] pick;
        logic [6:0] opc;
        logic [6:0] f7;
        pick = 4'(rand_bits(4));
        opc  = (pick < 4'd11) ? major_opc[pick] : 7'(rand_bits(7)); // mostly illegal
        case (2'(rand_bits(2)))
            2'd0:    f7 = 7'h00;
            2'd1:    f7 = 7'h20;
            2'd2:    f7 = 7'h01;
            default: f7 = 7'(rand_bits(7));
        endcase
        return {f7, 18'(rand_bits(18)), opc};
    endfunction

    function automatic logic [inst_w-1:0] load_to(input logic [reg_idx_w-1:0] dst);
        return {12'(rand_bits(12)), 5'(rand_bits(5)), 3'b011, dst, opc_load};
    endfunction

    task automatic drive_cycle();
        @(posedge clk);
        #2;
        if (!in_valid || pair_done) begin
            in_valid = traffic_on && (rand_bits(2) != 0);
            in_pc    = next_pc;
            in_inst  = rand_inst();
            next_pc  = next_pc + 4;
        end
        ex_ready       = (3'(rand_bits(3)) < ready_level);
        flush          = flush_on && (rand_bits(5) == 0);
        ex_stage_valid = hazard_on && rand_bits(1);
        case (2'(rand_bits(2)))
            2'd0:    ex_stage_inst = load_to(ex_inst[19:15]);
            2'd1:    ex_stage_inst = load_to(ex_inst[24:20]);
            2'd2:    ex_stage_inst = load_to(5'(rand_bits(5)));
            default: ex_stage_inst = rand_inst();
        endcase
        wb_en   = (rand_bits(2) == 0);
        wb_rd   = 5'(rand_bits(5));
        wb_data = rand_bits(64);
    endtask

    // reference model sampled mid-cycle while everything is stable
    always @(negedge clk) begin
        pair_t head;
        logic  hazard;
        int    occ;
        if (reset) begin
            exp_q.delete();
            foreach (model_regs[i]) begin
                model_regs[i] = '0;
            end
        end else begin
            hazard = 1'b0;
            occ    = (exp_q.size() > 0) ? exp_q.size() - 1 : 0; // slot holds one
            if (exp_q.size() > 0) begin
                head   = exp_q[0];
                hazard = ex_stage_valid && load_hit(head.inst, ex_stage_inst);
                assert (ex_pc === head.pc) else value_error("ex_pc", head.pc, ex_pc);
                assert (ex_inst === head.inst)
                    else value_error("ex_inst", 64'(head.inst), 64'(ex_inst));
            end
            assert (ex_valid === ((exp_q.size() > 0) && !hazard))
                else value_error("ex_valid", 64'((exp_q.size() > 0) && !hazard), 64'(ex_valid));
            assert (in_ready === (occ < queue_alm_full))
                else value_error("in_ready", 64'(occ < queue_alm_full), 64'(in_ready));
            if (ex_valid) begin
                assert (src_a === model_regs[ex_inst[19:15]])
                    else value_error("src_a", model_regs[ex_inst[19:15]], src_a);
                assert (src_b === model_regs[ex_inst[24:20]])
                    else value_error("src_b", model_regs[ex_inst[24:20]], src_b);
            end
            hazard_count += hazard;
            full_count   += !in_ready;
            if (ex_valid && ex_ready) begin
                void'(exp_q.pop_front());
                taken_count++;
            end
            if (flush) begin
                exp_q.delete(); // same-cycle input pair is dropped too
                flush_count++;
            end else if (in_valid && in_ready) begin
                exp_q.push_back(pair_t'({in_pc, in_inst}));
            end
            if (wb_en && wb_rd != '0) begin
                model_regs[wb_rd] = wb_data;
            end
            pair_done = in_valid && (in_ready || flush);
        end
    end

    assert property (@(posedge clk) disable iff (reset) ex_valid |-> op_class == ref_class(ex_inst))
        else value_error("op_class", 64'(ref_class($sampled(ex_inst))), 64'($sampled(op_class)));
    assert property (@(posedge clk) disable iff (reset) ex_valid |-> op == ref_op(ex_inst))
        else value_error("op", 64'(ref_op($sampled(ex_inst))), 64'($sampled(op)));
    assert property (@(posedge clk) disable iff (reset) ex_valid |-> rd == ex_inst[11:7])
        else value_error("rd", 64'($sampled(ex_inst[11:7])), 64'($sampled(rd)));
    assert property (@(posedge clk) disable iff (reset) ex_valid |-> imm == ref_imm(ex_inst))
        else value_error("imm", ref_imm($sampled(ex_inst)), $sampled(imm));
    assert property (@(posedge clk) disable iff (reset) flush |=> !ex_valid && in_ready)
        else plain_error("stage not empty in the cycle after a flush");
    assert property (@(posedge clk) disable iff (reset)
        ex_valid && !ex_ready && !flush |=> $stable(ex_pc) && $stable(ex_inst))
        else plain_error("slot changed while execute held ex_ready low");

    initial begin
        reset          = 1'b1;
        flush          = 1'b0;
        in_valid       = 1'b0;
        in_pc          = '0;
        in_inst        = '0;
        wb_en          = 1'b0;
        wb_rd          = '0;
        wb_data        = '0;
        ex_stage_valid = 1'b0;
        ex_stage_inst  = '0;
        ex_ready       = 1'b0;
        next_pc        = 64'h8000_0000;
        pair_done      = 1'b0;
        traffic_on     = 1'b0;
        hazard_on      = 1'b0;
        flush_on       = 1'b0;
        ready_level    = 0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        // every register gets a value and the x0 write is ignored
        for (int r = 0; r < reg_count; r++) begin
            @(posedge clk);
            #2;
            wb_en   = 1'b1;
            wb_rd   = 5'(r);
            wb_data = rand_bits(64);
        end
        traffic_on  = 1'b1;
        ready_level = 1; // slow execute so the queue runs up to almost full
        repeat (150) drive_cycle();
        ready_level = 6;
        hazard_on   = 1'b1;
        flush_on    = 1'b1;
        repeat (600) drive_cycle();
        traffic_on  = 1'b0;
        hazard_on   = 1'b0;
        flush_on    = 1'b0;
        ready_level = 8;
        for (int n = 0; n < 100 && (exp_q.size() != 0 || in_valid); n++) begin
            drive_cycle();
        end
        if (exp_q.size() != 0 || in_valid) begin
            plain_error("stage did not drain within 100 cycles");
        end
        // one pair into the empty stage
        @(posedge clk);
        #2;
        flush          = 1'b0;
        ex_stage_valid = 1'b0;
        ex_ready       = 1'b1;
        in_valid       = 1'b1;
        in_pc          = next_pc;
        in_inst        = rand_inst();
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        assert (ex_valid === 1'b1) else value_error("ex_valid", 64'(1), 64'(ex_valid));
        assert (ex_pc === in_pc) else value_error("ex_pc", in_pc, ex_pc);
        @(posedge clk);
        if (taken_count < 100 || hazard_count == 0 || flush_count == 0 || full_count == 0) begin
            plain_error("random stimulus missed issue, hazard, flush or full cases");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: verilog.f
common/rv_isa_pkg.sv
common/decode_pkg.sv
common/id_slot_if.sv
decode/fetch_buffer.sv
decode/inst_decoder.sv
decode/issue_ctrl.sv
hdl/reg_file.sv
hdl/decode_stage.sv
testbench/tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - common/rv_isa_pkg.sv
  - common/decode_pkg.sv
  - common/id_slot_if.sv
  - decode/fetch_buffer.sv
  - decode/inst_decoder.sv
  - decode/issue_ctrl.sv
  - hdl/reg_file.sv
  - hdl/decode_stage.sv
  - target: test
    files:
      - testbench/tb_decode_stage.sv
